// ==== source/vend_pkg.sv ====
package vend_pkg;

    typedef logic [7:0] credit_t;    // credit or coin amount
    typedef logic [1:0] drink_t;     // 0..3 for A, S, D, F
    typedef logic [7:0] key_code_t;
    typedef logic [7:0] seg_t;       // a b c d e f g dp, active low

    typedef enum logic [1:0] {
        VEND_IDLE     = 2'd0,
        VEND_DISPENSE = 2'd1,
        VEND_REFUND   = 2'd2
    } vend_state_t;

    localparam credit_t CREDIT_MAX = 8'd99;

    localparam credit_t COIN_SMALL = 8'd5;
    localparam credit_t COIN_MID   = 8'd10;
    localparam credit_t COIN_LARGE = 8'd50;

    // indexed by drink_t
    localparam credit_t DRINK_PRICE [0:3] = '{8'd20, 8'd25, 8'd30, 8'd60};

    // set 2 make codes
    localparam key_code_t KEY_A = 8'h1C;
    localparam key_code_t KEY_S = 8'h1B;
    localparam key_code_t KEY_D = 8'h23;
    localparam key_code_t KEY_F = 8'h2B;

    // consecutive high samples before a press counts
    localparam int DEBOUNCE_LEN = 4;

    // top bit of the refresh counter picks the digit
    localparam int REFRESH_BITS = 4;

endpackage

// ==== source/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press_pulse
);

    logic [vend_pkg::DEBOUNCE_LEN-1:0] sample_sr;
    logic                              debounced;
    logic                              debounced_q;

    // stable only once every stage has seen the button high
    assign debounced = &sample_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_sr   <= '0;
            debounced_q <= 1'b0;
            press_pulse <= 1'b0;
        end else begin
            sample_sr   <= {sample_sr[vend_pkg::DEBOUNCE_LEN-2:0], button};
            debounced_q <= debounced;
            press_pulse <= debounced & ~debounced_q;  // rising edge only
        end
    end

    // a held button must not retrigger
    a_single_cycle_pulse: assert property (
        @(posedge clk) disable iff (rst)
        press_pulse |=> !press_pulse
    ) else $error("press_pulse high for two cycles");

endmodule

// ==== source/coin_intake.sv ====
`timescale 1ns/1ps

module coin_intake (
    input  logic              clk,
    input  logic              rst,
    input  logic              coin_small_btn,
    input  logic              coin_mid_btn,
    input  logic              coin_large_btn,
    input  logic              cancel_btn,
    output logic              coin_pulse,
    output vend_pkg::credit_t coin_value,
    output logic              cancel_pulse
);

    logic small_pulse;
    logic mid_pulse;
    logic large_pulse;

    button_conditioner small_cond (
        .clk         (clk),
        .rst         (rst),
        .button      (coin_small_btn),
        .press_pulse (small_pulse)
    );

    button_conditioner mid_cond (
        .clk         (clk),
        .rst         (rst),
        .button      (coin_mid_btn),
        .press_pulse (mid_pulse)
    );

    button_conditioner large_cond (
        .clk         (clk),
        .rst         (rst),
        .button      (coin_large_btn),
        .press_pulse (large_pulse)
    );

    button_conditioner cancel_cond (
        .clk         (clk),
        .rst         (rst),
        .button      (cancel_btn),
        .press_pulse (cancel_pulse)
    );

    assign coin_pulse = small_pulse | mid_pulse | large_pulse;

    // one coin per cycle, small wins over mid over large
    always_comb begin
        if (small_pulse)
            coin_value = vend_pkg::COIN_SMALL;
        else if (mid_pulse)
            coin_value = vend_pkg::COIN_MID;
        else if (large_pulse)
            coin_value = vend_pkg::COIN_LARGE;
        else
            coin_value = '0;
    end

endmodule

// ==== source/drink_select.sv ====
`timescale 1ns/1ps

module drink_select (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_valid,
    input  logic                key_make,
    input  vend_pkg::key_code_t key_code,
    output logic                select_pulse,
    output vend_pkg::drink_t    select_drink
);

    logic             key_hit;   // code is one of the drink keys
    vend_pkg::drink_t key_idx;
    logic [3:0]       held;      // drink keys currently down

    always_comb begin
        key_hit = 1'b1;
        case (key_code)
            vend_pkg::KEY_A: key_idx = 2'd0;
            vend_pkg::KEY_S: key_idx = 2'd1;
            vend_pkg::KEY_D: key_idx = 2'd2;
            vend_pkg::KEY_F: key_idx = 2'd3;
            default: begin
                key_hit = 1'b0;
                key_idx = 2'd0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held         <= '0;
            select_pulse <= 1'b0;
        end else begin
            select_pulse <= 1'b0;
            if (key_valid && key_hit) begin
                if (key_make) begin
                    // typematic repeats see the key already held
                    select_pulse  <= ~held[key_idx];
                    held[key_idx] <= 1'b1;
                end else begin
                    held[key_idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid && key_hit && key_make)
            select_drink <= key_idx;
    end

endmodule

// ==== source/vend_controller.sv ====
`timescale 1ns/1ps

module vend_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              coin_pulse,
    input  logic              cancel_pulse,
    input  logic              select_pulse,
    input  vend_pkg::credit_t coin_value,
    input  vend_pkg::drink_t  select_drink,
    output vend_pkg::credit_t credit,
    output logic              dispense,
    output vend_pkg::drink_t  dispensed_drink,
    output logic              refund,
    output vend_pkg::credit_t refund_amount,
    output logic [3:0]        affordable
);

    vend_pkg::vend_state_t state;
    vend_pkg::credit_t     price;
    vend_pkg::credit_t     credit_sat;
    logic [8:0]            credit_sum;   // one extra bit for the carry

    assign price      = vend_pkg::DRINK_PRICE[select_drink];
    assign credit_sum = {1'b0, credit} + {1'b0, coin_value};
    assign credit_sat = (credit_sum > {1'b0, vend_pkg::CREDIT_MAX})
                        ? vend_pkg::CREDIT_MAX : credit_sum[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= vend_pkg::VEND_IDLE;
            credit <= '0;
        end else begin
            case (state)
                vend_pkg::VEND_IDLE: begin
                    if (cancel_pulse) begin
                        state  <= vend_pkg::VEND_REFUND;
                        credit <= '0;
                    end else if (select_pulse) begin
                        if (credit >= price) begin
                            state  <= vend_pkg::VEND_DISPENSE;
                            credit <= credit - price;
                        end
                        // short on credit, nothing happens
                    end else if (coin_pulse) begin
                        credit <= credit_sat;
                    end
                end
                default: state <= vend_pkg::VEND_IDLE;  // busy one cycle
            endcase
        end
    end

    // payload, only meaningful alongside the pulses
    always_ff @(posedge clk) begin
        if (state == vend_pkg::VEND_IDLE) begin
            dispensed_drink <= select_drink;
            refund_amount   <= credit;
        end
    end

    assign dispense = (state == vend_pkg::VEND_DISPENSE);
    assign refund   = (state == vend_pkg::VEND_REFUND);

    always_comb begin
        for (int i = 0; i < 4; i++)
            affordable[i] = (credit >= vend_pkg::DRINK_PRICE[i]);
    end

    a_credit_in_range: assert property (
        @(posedge clk) disable iff (rst)
        credit <= vend_pkg::CREDIT_MAX
    ) else $error("credit above saturation limit");

    a_vend_refund_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(dispense && refund)
    ) else $error("dispense and refund together");

endmodule

// ==== source/credit_display.sv ====
`timescale 1ns/1ps

module credit_display (
    input  logic              clk,
    input  logic              rst,
    input  vend_pkg::credit_t credit,
    output vend_pkg::seg_t    seg,
    output logic [3:0]        an
);

    logic [vend_pkg::REFRESH_BITS-1:0] refresh_cnt;
    logic                              digit_sel;   // 1 = tens
    vend_pkg::credit_t                 tens_full;
    vend_pkg::credit_t                 ones_full;
    logic [3:0]                        digit;

    function automatic vend_pkg::seg_t digit_to_seg(input logic [3:0] value);
        vend_pkg::seg_t pattern;
        case (value)
            4'd0:    pattern = 8'b0000_0011;
            4'd1:    pattern = 8'b1001_1111;
            4'd2:    pattern = 8'b0010_0101;
            4'd3:    pattern = 8'b0000_1101;
            4'd4:    pattern = 8'b1001_1001;
            4'd5:    pattern = 8'b0100_1001;
            4'd6:    pattern = 8'b0100_0001;
            4'd7:    pattern = 8'b0001_1111;
            4'd8:    pattern = 8'b0000_0001;
            4'd9:    pattern = 8'b0000_1001;
            default: pattern = 8'b0110_0000;  // not a decimal digit
        endcase
        return pattern;
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign digit_sel = refresh_cnt[vend_pkg::REFRESH_BITS-1];

    // credit is capped at 99, so both quotients fit a nibble
    assign tens_full = credit / 8'd10;
    assign ones_full = credit - tens_full * 8'd10;

    assign digit = digit_sel ? tens_full[3:0] : ones_full[3:0];
    assign seg   = digit_to_seg(digit);
    assign an    = digit_sel ? 4'b1101 : 4'b1110;

    a_anode_legal: assert property (
        @(posedge clk) disable iff (rst)
        an inside {4'b1110, 4'b1101}
    ) else $error("illegal anode code %b", an);

endmodule

// ==== source/vending_top.sv ====
`timescale 1ns/1ps

module vending_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                coin_small_btn,
    input  logic                coin_mid_btn,
    input  logic                coin_large_btn,
    input  logic                cancel_btn,
    input  logic                key_valid,
    input  logic                key_make,
    input  vend_pkg::key_code_t key_code,
    output vend_pkg::credit_t   credit,
    output logic                dispense,
    output vend_pkg::drink_t    dispensed_drink,
    output logic                refund,
    output vend_pkg::credit_t   refund_amount,
    output logic [3:0]          affordable,
    output vend_pkg::seg_t      seg,
    output logic [3:0]          an
);

    logic              coin_pulse;
    vend_pkg::credit_t coin_value;
    logic              cancel_pulse;
    logic              select_pulse;
    vend_pkg::drink_t  select_drink;

    coin_intake intake0 (
        .clk            (clk),
        .rst            (rst),
        .coin_small_btn (coin_small_btn),
        .coin_mid_btn   (coin_mid_btn),
        .coin_large_btn (coin_large_btn),
        .cancel_btn     (cancel_btn),
        .coin_pulse     (coin_pulse),
        .coin_value     (coin_value),
        .cancel_pulse   (cancel_pulse)
    );

    drink_select select0 (
        .clk          (clk),
        .rst          (rst),
        .key_valid    (key_valid),
        .key_make     (key_make),
        .key_code     (key_code),
        .select_pulse (select_pulse),
        .select_drink (select_drink)
    );

    vend_controller ctrl0 (
        .clk             (clk),
        .rst             (rst),
        .coin_pulse      (coin_pulse),
        .cancel_pulse    (cancel_pulse),
        .select_pulse    (select_pulse),
        .coin_value      (coin_value),
        .select_drink    (select_drink),
        .credit          (credit),
        .dispense        (dispense),
        .dispensed_drink (dispensed_drink),
        .refund          (refund),
        .refund_amount   (refund_amount),
        .affordable      (affordable)
    );

    credit_display display0 (
        .clk    (clk),
        .rst    (rst),
        .credit (credit),
        .seg    (seg),
        .an     (an)
    );

endmodule

// ==== tb/vending_tb.sv ====
`timescale 1ns/1ps

module vending_tb;

    localparam int RESET_CYCLES = 10;
    localparam int HOLD_MIN     = vend_pkg::DEBOUNCE_LEN + 2;
    localparam int HOLD_SPAN    = 7;                            // hold up to DEBOUNCE_LEN+8
    localparam int RELEASE_LEN  = vend_pkg::DEBOUNCE_LEN + 4;
    localparam int KEY_GAP      = 4;
    localparam int REFRESH_LEN  = 1 << vend_pkg::REFRESH_BITS;

    localparam int COIN_EVENTS      = 60;
    localparam int PURCHASE_EVENTS  = 80;
    localparam int TYPEMATIC_EVENTS = 30;
    localparam int CANCEL_ROUNDS    = 12;
    localparam int DISPLAY_CHECKS   = COIN_EVENTS / 10 + PURCHASE_EVENTS / 8 + CANCEL_ROUNDS + 2;

    localparam int PRESS_WORST = HOLD_MIN + HOLD_SPAN - 1 + RELEASE_LEN;
    localparam int KEY_WORST   = 1 + KEY_GAP;
    localparam int MAX_CYCLES  = 2 * (RESET_CYCLES
        + PRESS_WORST * (COIN_EVENTS + PURCHASE_EVENTS + 4 * CANCEL_ROUNDS + 8)
        + KEY_WORST * (2 * PURCHASE_EVENTS + TYPEMATIC_EVENTS)
        + REFRESH_LEN * DISPLAY_CHECKS);

    localparam logic [7:0] DRINK_KEYS [0:3] =
        '{vend_pkg::KEY_A, vend_pkg::KEY_S, vend_pkg::KEY_D, vend_pkg::KEY_F};

    logic                clk;
    logic                rst;
    logic                coin_small_btn;
    logic                coin_mid_btn;
    logic                coin_large_btn;
    logic                cancel_btn;
    logic                key_valid;
    logic                key_make;
    vend_pkg::key_code_t key_code;
    vend_pkg::credit_t   credit;
    logic                dispense;
    vend_pkg::drink_t    dispensed_drink;
    logic                refund;
    vend_pkg::credit_t   refund_amount;
    logic [3:0]          affordable;
    vend_pkg::seg_t      seg;
    logic [3:0]          an;

    int         seed = 32'h9243_d7ef;
    int         cycles = 0;
    int         model_credit;
    logic [3:0] model_held;         // drink keys the model thinks are down
    int         exp_dispenses;
    int         seen_dispenses;
    int         exp_refunds;
    int         seen_refunds;
    int         exp_drink;
    int         exp_refund_amount;
    int         errors;
    int         checks;
    int         test_errors_start;

    vending_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .coin_small_btn  (coin_small_btn),
        .coin_mid_btn    (coin_mid_btn),
        .coin_large_btn  (coin_large_btn),
        .cancel_btn      (cancel_btn),
        .key_valid       (key_valid),
        .key_make        (key_make),
        .key_code        (key_code),
        .credit          (credit),
        .dispense        (dispense),
        .dispensed_drink (dispensed_drink),
        .refund          (refund),
        .refund_amount   (refund_amount),
        .affordable      (affordable),
        .seg             (seg),
        .an              (an)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int drink_index(input logic [7:0] code);
        for (int i = 0; i < 4; i++)
            if (code == DRINK_KEYS[i])
                return i;
        return -1;
    endfunction

    // a..g with 1 = lit, dp stays dark
    function automatic logic [7:0] seg_pattern(input int value);
        logic [6:0] lit;
        case (value)
            0:       lit = 7'b1111110;
            1:       lit = 7'b0110000;
            2:       lit = 7'b1101101;
            3:       lit = 7'b1111001;
            4:       lit = 7'b0110011;
            5:       lit = 7'b1011011;
            6:       lit = 7'b1011111;
            7:       lit = 7'b1110000;
            8:       lit = 7'b1111111;
            default: lit = 7'b1111011;
        endcase
        return {~lit, 1'b1};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state();
        compare_value("credit", credit, model_credit);
        for (int i = 0; i < 4; i++)
            compare_value($sformatf("affordable[%0d]", i), affordable[i],
                          model_credit >= vend_pkg::DRINK_PRICE[i]);
        compare_value("dispense pulses", seen_dispenses, exp_dispenses);
        compare_value("refund pulses", seen_refunds, exp_refunds);
    endtask

    // pulses are checked as soon as they show up
    always @(negedge clk) begin
        if (!rst && dispense) begin
            seen_dispenses = seen_dispenses + 1;
            assert (seen_dispenses <= exp_dispenses) else begin
                $display("Dispense pulse for drink %0d that was not expected", dispensed_drink);
                errors++;
            end
            compare_value("dispensed_drink", dispensed_drink, exp_drink);
        end
        if (!rst && refund) begin
            seen_refunds = seen_refunds + 1;
            assert (seen_refunds <= exp_refunds) else begin
                $display("Refund pulse that was not expected");
                errors++;
            end
            compare_value("refund_amount", refund_amount, exp_refund_amount);
        end
    end

    task automatic set_button(input int which, input logic level);
        case (which)
            0:       coin_small_btn = level;
            1:       coin_mid_btn   = level;
            2:       coin_large_btn = level;
            default: cancel_btn     = level;
        endcase
    endtask

    task automatic press_button(input int which);
        int hold;
        hold = HOLD_MIN + int'($unsigned($random(seed)) % HOLD_SPAN);
        set_button(which, 1'b1);
        repeat (hold) @(negedge clk);
        set_button(which, 1'b0);
        repeat (RELEASE_LEN) @(negedge clk);
    endtask

    task automatic insert_coin(input int kind);
        int value;
        case (kind)
            0:       value = vend_pkg::COIN_SMALL;
            1:       value = vend_pkg::COIN_MID;
            default: value = vend_pkg::COIN_LARGE;
        endcase
        model_credit = model_credit + value;
        if (model_credit > vend_pkg::CREDIT_MAX)
            model_credit = vend_pkg::CREDIT_MAX;
        press_button(kind);
        check_state();
    endtask

    task automatic cancel_credit();
        exp_refund_amount = model_credit;
        exp_refunds++;
        model_credit = 0;
        press_button(3);
        check_state();
    endtask

    task automatic key_event(input logic [7:0] code, input logic make);
        int idx;
        idx = drink_index(code);
        if (idx >= 0) begin
            if (make && !model_held[idx] && model_credit >= vend_pkg::DRINK_PRICE[idx]) begin
                exp_dispenses++;
                exp_drink = idx;
                model_credit = model_credit - vend_pkg::DRINK_PRICE[idx];
            end
            model_held[idx] = make;
        end
        key_code  = code;
        key_make  = make;
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
        key_make  = 1'b0;
        repeat (KEY_GAP) @(negedge clk);
        check_state();
    endtask

    task automatic sample_display();
        repeat (REFRESH_LEN) begin
            @(negedge clk);
            checks++;
            assert (an == 4'b1110 || an == 4'b1101) else begin
                $display("Anode select %b is neither the ones nor the tens digit", an);
                errors++;
            end
            if (an == 4'b1110)
                compare_value("seg (ones)", seg, seg_pattern(model_credit % 10));
            else if (an == 4'b1101)
                compare_value("seg (tens)", seg, seg_pattern(model_credit / 10));
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors_start);
        test_errors_start = errors;
    endtask

    initial begin
        logic [7:0] code;
        int         start_dispenses;
        rst            = 1'b1;
        coin_small_btn = 1'b0;
        coin_mid_btn   = 1'b0;
        coin_large_btn = 1'b0;
        cancel_btn     = 1'b0;
        key_valid      = 1'b0;
        key_make       = 1'b0;
        key_code       = '0;
        model_credit   = 0;
        model_held     = '0;
        exp_dispenses  = 0;
        seen_dispenses = 0;
        exp_refunds    = 0;
        seen_refunds   = 0;
        exp_drink      = 0;
        exp_refund_amount = 0;
        errors         = 0;
        checks         = 0;
        test_errors_start = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_value("dispense", dispense, 0);
        compare_value("refund", refund, 0);
        check_state();

        for (int n = 0; n < COIN_EVENTS; n++) begin
            insert_coin(int'($unsigned($random(seed)) % 3));
            if (n % 10 == 0)
                sample_display();
        end
        report_test("coin accumulation");

        // coins and drink keys mixed, each key released before the next event
        for (int n = 0; n < PURCHASE_EVENTS; n++) begin
            if ($unsigned($random(seed)) % 5 < 2) begin
                insert_coin(int'($unsigned($random(seed)) % 3));
            end else begin
                code = DRINK_KEYS[$unsigned($random(seed)) % 4];
                key_event(code, 1'b1);
                key_event(code, 1'b0);
            end
            if (n % 8 == 0)
                sample_display();
        end
        report_test("purchase");

        insert_coin(2);
        insert_coin(2);                     // credit is 99 from here
        start_dispenses = seen_dispenses;
        key_event(vend_pkg::KEY_A, 1'b1);
        repeat (3) key_event(vend_pkg::KEY_A, 1'b1);  // typematic repeats
        for (int n = 0; n < 8; n++) begin
            code = $random(seed);
            if (drink_index(code) >= 0)
                code = 8'h15;
            key_event(code, 1'b1);
            key_event(code, 1'b0);
        end
        key_event(vend_pkg::KEY_A, 1'b0);
        key_event(vend_pkg::KEY_A, 1'b1);
        key_event(vend_pkg::KEY_A, 1'b0);
        compare_value("dispenses in typematic test", seen_dispenses - start_dispenses, 2);
        report_test("typematic and foreign keys");

        cancel_credit();
        cancel_credit();                    // nothing left, refund of 0
        sample_display();
        for (int n = 0; n < CANCEL_ROUNDS; n++) begin
            repeat ($unsigned($random(seed)) % 4)
                insert_coin(int'($unsigned($random(seed)) % 3));
            sample_display();
            cancel_credit();
        end
        report_test("cancel");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/vend_pkg.sv
source/button_conditioner.sv
source/coin_intake.sv
source/drink_select.sv
source/vend_controller.sv
source/credit_display.sv
source/vending_top.sv
tb/vending_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module vending_tb -o vending_sim \
    && ./obj_dir/vending_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
